// ==== Bender.yml ====
package:
  name: decOpWex2

sources:
  - decPkg.sv
  - decWindowReg.sv
  - decSlot.sv
  - decDualLane.sv
  - decLaneSteer.sv
  - decOpWex2.sv
  - target: test
    files:
      - decOpWex2_chk.sv
      - tbDecOpWex2.sv

// ==== decDualLane.sv ====
// Spreads a dual-lane op over both lanes, pairing each register across lane A and lane B
`timescale 1ns/1ps

module decDualLane
	import decPkg::*;
(
	input  laneOpT laneIn,
	input  logic   dualEn,
	output laneOpT laneA,
	output laneOpT laneB
);

	logic pairSwap;

	// Even/odd half of a register pair, ZZR stays ZZR
	function automatic gprIdxT pairReg(gprIdxT r, logic s);
		return (r == GPR_ZZR) ? GPR_ZZR : {1'b0, r[4:1], s};
	endfunction

	assign pairSwap = laneIn.uCmd == UCMD_WXCMP; // Compare takes the high half on lane A

	always_comb
	begin
		laneA = laneIn;
		laneB = LANE_NOP;

		if (dualEn)
		begin
			laneB = laneIn; // Same op and immediate on both lanes

			laneA.regN = pairReg(laneIn.regN, pairSwap);
			laneA.regM = pairReg(laneIn.regM, pairSwap);
			laneA.regO = pairReg(laneIn.regO, pairSwap);

			laneB.regN = pairReg(laneIn.regN, !pairSwap);
			laneB.regM = pairReg(laneIn.regM, !pairSwap);
			laneB.regO = pairReg(laneIn.regO, !pairSwap);
		end
	end

endmodule

// ==== decLaneSteer.sv ====
// Output stage, steers the two slot decodes onto lanes A and B and registers the result
`timescale 1ns/1ps

module decLaneSteer
	import decPkg::*;
#(
	parameter bit jumboEnable = 1'b1
)
(
	input  logic          clock,
	input  logic          arstN,
	input  logic          winValid,
	input  logic          winWxe,
	input  slotDecT [1:0] slotDec,
	output logic          idValid,
	output laneOpT        idLaneA,
	output laneOpT        idLaneB
);

	typedef enum logic [2:0]
	{
		STEER_SHORT,   // 16-bit op in slot A
		STEER_JUMBO,   // Prefix in A extends B
		STEER_INVALID, // Both slots WEX flagged
		STEER_WEX,     // A and B issued together, swapped
		STEER_SCALAR
	} steerT;

	steerT  steer;
	logic   wexA;
	logic   wexB;
	logic   dualEn;
	laneOpT laneSel;
	laneOpT dualA;
	laneOpT dualB;
	laneOpT laneBNext;

	function automatic laneOpT toLane(slotDecT d);
		laneOpT l;
		l.uCmd = d.uCmd;
		l.uIxt = d.uIxt;
		l.pred = d.pred;
		l.regN = d.regN;
		l.regM = d.regM;
		l.regO = d.regO;
		l.imm  = d.imm;
		return l;
	endfunction

	assign wexA = slotDec[0].wexFlag & slotDec[0].isFx & winWxe;
	assign wexB = slotDec[1].wexFlag & slotDec[1].isFx & winWxe;

	always_comb
	begin
		if (!slotDec[0].isFx)
			steer = STEER_SHORT;
		else if (jumboEnable && slotDec[0].isJumbo)
			steer = STEER_JUMBO;
		else if (wexA && wexB)
			steer = STEER_INVALID;
		else if (wexA)
			steer = STEER_WEX;
		else
			steer = STEER_SCALAR;
	end

	always_comb
	begin
		laneSel = toLane(slotDec[0]);
		case (steer)
			STEER_JUMBO:
			begin
				laneSel     = toLane(slotDec[1]);
				// Slot B bits 30:21 sit at jumboBits[14:5] of its own record
				laneSel.imm = {slotDec[0].jumboBits[JUMBO_IMM_W-1:0],
					slotDec[1].jumboBits[IMM_LSB - HI_LSB +: IMM_W]};
			end
			STEER_INVALID:
			begin
				laneSel      = LANE_NOP;
				laneSel.uCmd = UCMD_INVOP;
			end
			STEER_WEX:
				laneSel = toLane(slotDec[1]); // Later slot goes first
			default:
				laneSel = toLane(slotDec[0]);
		endcase
	end

	assign dualEn = (steer inside {STEER_SHORT, STEER_JUMBO, STEER_SCALAR}) &&
		(laneSel.uCmd inside {UCMD_WXADD, UCMD_WXCMP});

	decDualLane uDual
	(
		.laneIn (laneSel),
		.dualEn (dualEn),
		.laneA  (dualA),
		.laneB  (dualB)
	);

	assign laneBNext = (steer == STEER_WEX) ? toLane(slotDec[0]) : dualB;

	// Lanes hold across idle cycles
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			idValid <= 1'b0;
			idLaneA <= LANE_NOP;
			idLaneB <= LANE_NOP;
		end
		else
		begin
			idValid <= winValid;
			if (winValid)
			begin
				idLaneA <= dualA;
				idLaneB <= laneBNext;
			end
		end
	end

endmodule

// ==== decOpWex2.sv ====
// Two-wide WEX decoder top, window register feeding two slot decoders and the lane steering
`timescale 1ns/1ps

module decOpWex2
	import decPkg::*;
#(
	parameter bit jumboEnable = 1'b1
)
(
	input  logic        clock,
	input  logic        arstN,
	input  logic        istrValid,
	input  logic [63:0] istrWord,
	input  logic        srWxe,
	output logic        idValid,
	output laneOpT      idLaneA,
	output laneOpT      idLaneB
);

	logic [1:0][31:0] slotWord;
	logic             winValid;
	logic             winWxe;
	slotDecT [1:0]    slotDec;

	decWindowReg uWindow
	(
		.clock     (clock),
		.arstN     (arstN),
		.istrValid (istrValid),
		.istrWord  (istrWord),
		.srWxe     (srWxe),
		.winValid  (winValid),
		.winWxe    (winWxe),
		.slotWord  (slotWord)
	);

	// Slot A and slot B
	for (genvar i = 0; i < 2; i++)
	begin : gSlot
		decSlot uSlot
		(
			.slotWord (slotWord[i]),
			.slotDec  (slotDec[i])
		);
	end

	decLaneSteer #(.jumboEnable(jumboEnable)) uSteer
	(
		.clock    (clock),
		.arstN    (arstN),
		.winValid (winValid),
		.winWxe   (winWxe),
		.slotDec  (slotDec),
		.idValid  (idValid),
		.idLaneA  (idLaneA),
		.idLaneB  (idLaneB)
	);

endmodule

// ==== decOpWex2_chk.sv ====
// Concurrent checks on the decoder outputs that are bound into the top level for simulation
`timescale 1ns/1ps

module decOpWex2Chk
	import decPkg::*;
(
	input logic   clock,
	input logic   arstN,
	input logic   istrValid,
	input logic   idValid,
	input laneOpT idLaneA,
	input laneOpT idLaneB
);

	int failCount = 0; // Assertion failures so far

	// Window register plus output register
	aValidLatency: assert property (@(posedge clock) disable iff (!arstN)
		idValid == $past(istrValid, 2))
	else
	begin
		failCount++;
		$error("idValid does not follow istrValid by two cycles");
	end

	aInvopAlone: assert property (@(posedge clock) disable iff (!arstN)
		idLaneA.uCmd == UCMD_INVOP |-> idLaneB == LANE_NOP)
	else
	begin
		failCount++;
		$error("lane B is not NOP beside an invalid op on lane A");
	end

	aNopRegs: assert property (@(posedge clock) disable iff (!arstN)
		idLaneB.uCmd == UCMD_NOP |-> (idLaneB.regN == GPR_ZZR &&
			idLaneB.regM == GPR_ZZR && idLaneB.regO == GPR_ZZR))
	else
	begin
		failCount++;
		$error("NOP on lane B carries a register other than ZZR");
	end

endmodule

bind decOpWex2 decOpWex2Chk uChk
(
	.clock     (clock),
	.arstN     (arstN),
	.istrValid (istrValid),
	.idValid   (idValid),
	.idLaneA   (idLaneA),
	.idLaneB   (idLaneB)
);

// ==== decPkg.sv ====
// Shared types, opcodes and field positions of the two-wide decoder, imported by RTL and testbench
package decPkg;

	// Register index and the null register
	typedef logic [5:0] gprIdxT;
	localparam gprIdxT GPR_ZZR = 6'd63;

	typedef logic [32:0] immT;

	// Simplified micro-op set
	typedef enum logic [3:0]
	{
		UCMD_NOP   = 4'h0,
		UCMD_MOV   = 4'h1,
		UCMD_ADD   = 4'h2,
		UCMD_SUB   = 4'h3,
		UCMD_AND   = 4'h4,
		UCMD_OR    = 4'h5,
		UCMD_XOR   = 4'h6,
		UCMD_LOAD  = 4'h7,
		UCMD_STORE = 4'h8,
		UCMD_SHAD  = 4'h9,
		UCMD_CMP   = 4'hA,
		UCMD_WXADD = 4'hB, // Dual-lane add
		UCMD_WXCMP = 4'hC, // Dual-lane compare, lanes swapped
		UCMD_INVOP = 4'hD,
		UCMD_RSVE  = 4'hE, // Reserved, decodes as NOP
		UCMD_RSVF  = 4'hF
	} uCmdT;

	typedef enum logic [1:0]
	{
		PRED_ALWAYS = 2'd0,
		PRED_TRUE   = 2'd1,
		PRED_FALSE  = 2'd2
	} predT;

	// Prefix patterns of the slot's low halfword
	localparam logic [2:0] FX_PREFIX    = 3'b111;     // lo[15:13], 32-bit form
	localparam logic [6:0] JUMBO_PREFIX = 7'b1111111; // lo[15:9]

	// Bit positions within a 32-bit slot word
	localparam int E_FORM_BIT  = 12; // Clear for predicated E form
	localparam int PRED_BIT    = 10; // E form sense, F form WEX flag
	localparam int WEX_E_HI    = 11;
	localparam int WEX_E_LO    = 9;
	localparam int HI_LSB      = 16; // Start of upper halfword, also Rn
	localparam int IMM_SEL_BIT = 31; // Set selects immediate over Rm/Ro
	localparam int IMM_LSB     = 21;
	localparam int IMM_W       = 10;
	localparam int REG_W       = 5;
	localparam int JUMBO_IMM_W = 23; // Jumbo bits merged above the slot B immediate

	// One decoded slot, before steering
	typedef struct packed
	{
		logic        isFx;
		logic        isJumbo;
		logic        wexFlag;   // Raw flag, srWxe not applied
		predT        pred;
		gprIdxT      regN;
		gprIdxT      regM;
		gprIdxT      regO;
		immT         imm;
		uCmdT        uCmd;
		logic [4:0]  uIxt;
		logic [24:0] jumboBits;
	} slotDecT;

	// One issued lane
	typedef struct packed
	{
		uCmdT       uCmd;
		logic [4:0] uIxt;
		predT       pred;
		gprIdxT     regN;
		gprIdxT     regM;
		gprIdxT     regO;
		immT        imm;
	} laneOpT;

	localparam laneOpT LANE_NOP = '{
		uCmd: UCMD_NOP,
		uIxt: 5'd0,
		pred: PRED_ALWAYS,
		regN: GPR_ZZR,
		regM: GPR_ZZR,
		regO: GPR_ZZR,
		imm:  '0
	};

endpackage

// ==== decSlot.sv ====
// Decodes one 32-bit slot word into its form flags, predicate, registers and immediate
`timescale 1ns/1ps

module decSlot
	import decPkg::*;
(
	input  logic [31:0] slotWord,
	output slotDecT     slotDec
);

	logic [15:0] lo;
	logic        isFx;
	logic        isEForm;
	logic        immForm;
	uCmdT        rawCmd;

	assign lo      = slotWord[15:0];
	assign isFx    = lo[15:13] == FX_PREFIX;
	assign isEForm = isFx && !lo[E_FORM_BIT];
	assign immForm = slotWord[IMM_SEL_BIT];
	assign rawCmd  = uCmdT'(slotWord[3:0]);

	always_comb
	begin
		slotDec.isFx    = isFx;
		slotDec.isJumbo = lo[15:9] == JUMBO_PREFIX;

		// Raw bits, only meaningful for a jumbo prefix
		slotDec.jumboBits = {lo[8:0], slotWord[31:HI_LSB]};

		if (rawCmd == UCMD_RSVE || rawCmd == UCMD_RSVF)
			slotDec.uCmd = UCMD_NOP;
		else
			slotDec.uCmd = rawCmd;

		if (isEForm)
		begin
			slotDec.pred    = lo[PRED_BIT] ? PRED_FALSE : PRED_TRUE;
			slotDec.wexFlag = lo[WEX_E_HI] & lo[WEX_E_LO];
		end
		else if (isFx)
		begin
			slotDec.pred    = PRED_ALWAYS;
			slotDec.wexFlag = lo[PRED_BIT];
		end
		else
		begin
			slotDec.pred    = PRED_ALWAYS;
			slotDec.wexFlag = 1'b0;
		end

		if (isFx)
		begin
			slotDec.uIxt = slotWord[8:4];
			slotDec.regN = {1'b0, slotWord[HI_LSB +: REG_W]};
			if (immForm)
			begin
				slotDec.regM = GPR_ZZR;
				slotDec.regO = GPR_ZZR;
				slotDec.imm  = {{($bits(immT) - IMM_W){slotWord[IMM_LSB + IMM_W - 1]}},
					slotWord[IMM_LSB +: IMM_W]};
			end
			else
			begin
				slotDec.regM = {1'b0, slotWord[IMM_LSB +: REG_W]};         // 25:21
				slotDec.regO = {1'b0, slotWord[IMM_LSB + REG_W +: REG_W]}; // 30:26
				slotDec.imm  = '0;
			end
		end
		else
		begin
			// 16-bit op, 4-bit register fields
			slotDec.uIxt = 5'd0;
			slotDec.regN = {2'b00, lo[11:8]};
			slotDec.regM = {2'b00, lo[7:4]};
			slotDec.regO = GPR_ZZR;
			slotDec.imm  = '0;
		end
	end

endmodule

// ==== decWindowReg.sv ====
// Input stage of the decoder, captures each fetch window and hands its two slot words on
`timescale 1ns/1ps

module decWindowReg
(
	input  logic             clock,
	input  logic             arstN,
	input  logic             istrValid,
	input  logic [63:0]      istrWord,
	input  logic             srWxe,
	output logic             winValid,
	output logic             winWxe,
	output logic [1:0][31:0] slotWord
);

	logic [63:0] winWord;

	// Strobe and mode follow the window
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			winValid <= 1'b0;
			winWxe   <= 1'b0;
		end
		else
		begin
			winValid <= istrValid;
			if (istrValid)
				winWxe <= srWxe;
		end
	end

	always_ff @(posedge clock)
	begin
		if (istrValid)
			winWord <= istrWord;
	end

	assign slotWord[0] = winWord[31:0];  // Slot A
	assign slotWord[1] = winWord[63:32]; // Slot B

endmodule

// ==== list.f ====
decPkg.sv
decWindowReg.sv
decSlot.sv
decDualLane.sv
decLaneSteer.sv
decOpWex2.sv
decOpWex2_chk.sv
tbDecOpWex2.sv

// ==== tbDecOpWex2.sv ====
// Top-level testbench that drives random fetch windows into the decoder and checks both lanes
`timescale 1ns/1ps

module tbDecOpWex2
	import decPkg::*;
();

	localparam bit JUMBO_EN       = 1'b1;
	localparam int WINDOWS        = 200;               // Per test
	localparam int TIMEOUT_CYCLES = 6 * WINDOWS + 300; // Six tests plus idle cycles and drain

	typedef struct packed
	{
		laneOpT a;
		laneOpT b;
	} lanePairT;

	logic        clock;
	logic        arstN;
	logic        istrValid;
	logic [63:0] istrWord;
	logic        srWxe;
	logic        idValid;
	laneOpT      idLaneA;
	laneOpT      idLaneB;

	lanePairT expQ[$];
	lanePairT lastExp = '{a: LANE_NOP, b: LANE_NOP}; // Reset value of both lanes
	lanePairT popped;
	int       errCount   = 0;
	int       checkCount = 0;
	int       cycles     = 0;

	decOpWex2 #(.jumboEnable(JUMBO_EN)) DUT
	(
		.clock     (clock),
		.arstN     (arstN),
		.istrValid (istrValid),
		.istrWord  (istrWord),
		.srWxe     (srWxe),
		.idValid   (idValid),
		.idLaneA   (idLaneA),
		.idLaneB   (idLaneB)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic compareVal(string what, logic [63:0] got, logic [63:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Reference decode of one slot word
	function automatic laneOpT refDecode(logic [31:0] w);
		laneOpT l;
		l = LANE_NOP;
		l.uCmd = (w[3:0] >= 4'hE) ? UCMD_NOP : uCmdT'(w[3:0]);
		if (w[15:13] != 3'b111)
		begin
			l.regN = {2'b00, w[11:8]};
			l.regM = {2'b00, w[7:4]};
			return l;
		end
		l.uIxt = w[8:4];
		l.regN = {1'b0, w[20:16]};
		if (!w[12])
			l.pred = w[10] ? PRED_FALSE : PRED_TRUE; // E form
		if (w[31])
			l.imm = {{23{w[30]}}, w[30:21]}; // Rm and Ro stay ZZR
		else
		begin
			l.regM = {1'b0, w[25:21]};
			l.regO = {1'b0, w[30:26]};
		end
		return l;
	endfunction

	function automatic logic wexOf(logic [31:0] w, logic wxe);
		return wxe && w[15:13] == 3'b111 && (w[12] ? w[10] : (w[11] & w[9]));
	endfunction

	function automatic gprIdxT pairIdx(gprIdxT r, logic s);
		return (r == GPR_ZZR) ? r : ((r & 6'h1E) | 6'(s));
	endfunction

	function automatic lanePairT refWindow(logic [63:0] win, logic wxe);
		lanePairT    p;
		logic [31:0] a;
		logic [31:0] b;
		logic        single; // Case open to dual-lane pairing
		logic        s;
		a = win[31:0];
		b = win[63:32];
		p.b = LANE_NOP;
		single = 1'b1;
		if (a[15:13] != 3'b111)
			p.a = refDecode(a);
		else if (JUMBO_EN && a[15:9] == 7'h7F)
		begin
			p.a = refDecode(b);
			p.a.imm = {a[6:0], a[31:16], b[30:21]};
		end
		else if (wexOf(a, wxe) && wexOf(b, wxe))
		begin
			p.a = LANE_NOP;
			p.a.uCmd = UCMD_INVOP;
			single = 1'b0;
		end
		else if (wexOf(a, wxe))
		begin
			p.a = refDecode(b);
			p.b = refDecode(a);
			single = 1'b0;
		end
		else
			p.a = refDecode(a);
		if (single && (p.a.uCmd == UCMD_WXADD || p.a.uCmd == UCMD_WXCMP))
		begin
			s = p.a.uCmd == UCMD_WXCMP;
			p.b = p.a;
			p.a.regN = pairIdx(p.b.regN, s);
			p.a.regM = pairIdx(p.b.regM, s);
			p.a.regO = pairIdx(p.b.regO, s);
			p.b.regN = pairIdx(p.b.regN, !s);
			p.b.regM = pairIdx(p.b.regM, !s);
			p.b.regO = pairIdx(p.b.regO, !s);
		end
		return p;
	endfunction

	function automatic logic coin();
		return 1'($urandom_range(1, 0));
	endfunction

	function automatic logic [3:0] randCmd();
		return 4'($urandom_range(12, 1)); // No NOP, INVOP or reserved code
	endfunction

	function automatic logic [31:0] shortWord(logic [3:0] cmd);
		logic [31:0] w;
		w = $urandom;
		w[15] = w[15] & ~(w[14] & w[13]); // Keep out of the Fx space
		w[3:0] = cmd;
		return w;
	endfunction

	function automatic logic [31:0] fxWord(logic eForm, logic wex, logic [3:0] cmd);
		logic [31:0] w;
		w = $urandom;
		w[15:12] = {3'b111, !eForm};
		w[3:0] = cmd;
		if (eForm)
		begin
			w[11] = w[11] | wex;
			w[9] = wex | (w[9] & !w[11]);
		end
		else
		begin
			w[10] = wex;
			w[11] = w[11] & !(w[10] & w[9]); // Not a jumbo prefix
		end
		return w;
	endfunction

	task automatic buildWindow(int kind, output logic [63:0] w, output logic wxe);
		logic [31:0] a;
		logic [3:0]  cmd;
		wxe = coin();
		case (kind)
			1: w = {$urandom, shortWord(4'($urandom))}; // Any code, reserved ones too
			2:
			begin
				w = {$urandom, fxWord(coin(), coin(), 4'($urandom))};
				wxe = 1'b0;
			end
			3:
			begin
				a = coin() ? fxWord(coin(), 1'b0, randCmd()) : shortWord(randCmd());
				w = {a, fxWord(coin(), 1'b1, randCmd())};
				wxe = 1'b1;
			end
			4:
			begin
				w = {fxWord(coin(), 1'b1, randCmd()), fxWord(coin(), 1'b1, randCmd())};
				wxe = 1'b1;
			end
			5:
			begin
				a = $urandom;
				a[15:9] = JUMBO_PREFIX;
				w = {fxWord(coin(), coin(), randCmd()), a};
			end
			default:
			begin
				cmd = coin() ? UCMD_WXCMP : UCMD_WXADD;
				w = {$urandom, coin() ? fxWord(coin(), 1'b0, cmd) : shortWord(cmd)};
			end
		endcase
	endtask

	task automatic sendWindow(logic [63:0] w, logic wxe);
		@(posedge clock);
		if ($urandom_range(15, 0) == 0)
		begin
			istrValid <= 1'b0; // Idle cycle with the lanes held
			istrWord <= {$urandom, $urandom};
			srWxe <= coin();
			@(posedge clock);
		end
		istrValid <= 1'b1;
		istrWord <= w;
		srWxe <= wxe;
	endtask

	task automatic runTest(int kind, string name);
		logic [63:0] w;
		logic        wxe;
		logic [63:0] saved [WINDOWS / 2];
		int          errBefore;
		errBefore = errCount;
		for (int i = 0; i < WINDOWS; i++)
		begin
			if (kind == 3 && i >= WINDOWS / 2)
			begin
				w = saved[i - WINDOWS / 2]; // Same windows with WEX off
				wxe = 1'b0;
			end
			else
				buildWindow(kind, w, wxe);
			if (kind == 3 && i < WINDOWS / 2)
				saved[i] = w;
			sendWindow(w, wxe);
		end
		@(posedge clock);
		istrValid <= 1'b0;
		repeat (2) @(posedge clock);
		while (expQ.size() != 0)
			@(posedge clock);
		$display("Test %0d %s: %0d windows, %0d errors", kind, name, WINDOWS,
			errCount - errBefore);
	endtask

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	// Model follows the DUT inputs and pops expected lanes in order
	always @(posedge clock)
	begin
		if (arstN)
		begin
			if (idValid && expQ.size() == 0)
			begin
				errCount++;
				$display("Output strobe at %0t ns with no window outstanding", $time);
			end
			else if (idValid)
			begin
				popped = expQ.pop_front();
				compareVal("lane A", idLaneA, popped.a);
				compareVal("lane B", idLaneB, popped.b);
				lastExp = popped;
			end
			else
			begin
				compareVal("held lane A", idLaneA, lastExp.a);
				compareVal("held lane B", idLaneB, lastExp.b);
			end
			if (istrValid)
				expQ.push_back(refWindow(istrWord, srWxe));
		end
	end

	initial
	begin
		void'($urandom(72));
		arstN = 1'b0;
		istrValid = 1'b0;
		istrWord = '0;
		srWxe = 1'b0;
		repeat (4) @(posedge clock);
		arstN <= 1'b1;
		runTest(1, "short ops");
		runTest(2, "scalar E/F forms");
		runTest(3, "WEX pairs");
		runTest(4, "invalid WEX pair");
		runTest(5, "jumbo immediate");
		runTest(6, "dual lane");
		errCount += DUT.uChk.failCount; // Bound assertion failures
		$display("Summary: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
